//--- Bender.yml
package:
  name: ddr2_cpu_if

sources:
  - common/ddr2_cpu_pkg.sv
  - rtl/ddr2_wb_decode.sv
  - ddr2_ctrl_regs/ddr2_ctrl_regs.sv
  - ddr2_mem_window/ddr2_mem_window.sv
  - rtl/ddr2_bus_arbiter.sv
  - rtl/ddr2_cpu_if_top.sv
  - target: test
    files:
      - testbench/tb_ddr2_mem_model.sv
      - testbench/tb_ddr2_cpu_if.sv

//--- all.f
common/ddr2_cpu_pkg.sv
rtl/ddr2_wb_decode.sv
ddr2_ctrl_regs/ddr2_ctrl_regs.sv
ddr2_mem_window/ddr2_mem_window.sv
rtl/ddr2_bus_arbiter.sv
rtl/ddr2_cpu_if_top.sv
testbench/tb_ddr2_mem_model.sv
testbench/tb_ddr2_cpu_if.sv

//--- common/ddr2_cpu_pkg.sv
package ddr2_cpu_pkg;

  // Register indices, taken from word address bits 3 to 1.
  localparam logic [2:0] REG_PHY_READY = 3'd0;
  localparam logic [2:0] REG_SOFT_ADDR = 3'd1;
  localparam logic [2:0] REG_RESET     = 3'd2;
  localparam logic [2:0] REG_BUS_RQST  = 3'd3;
  localparam logic [2:0] REG_BUS_GRNTD = 3'd4;
  localparam logic [2:0] REG_WIN_ERR   = 3'd5;

  // Byte address bit 16 picks the region, 0 for registers and 1 for the window.
  localparam int WIN_SEL_BIT = 16;

  // Word offset bits inside the window, byte address bits 15 to 1.
  localparam int WIN_OFS_BITS = 15;

  // Single-word command toward the DDR2 controller.
  typedef struct packed {
    logic        valid;
    logic        we;
    logic [1:0]  sel;
    logic [31:0] addr;
    logic [15:0] wdata;
  } mem_cmd_t;

  // Response from the DDR2 controller.
  typedef struct packed {
    logic        ready;  // Command accepted this cycle.
    logic        rvalid; // Read data is valid.
    logic [15:0] rdata;
  } mem_rsp_t;

endpackage

//--- ddr2_ctrl_regs/ddr2_ctrl_regs.sv
module ddr2_ctrl_regs
  import ddr2_cpu_pkg::*;
#(
  parameter int SOFT_ADDR_BITS = 12
) (
  input  logic                      wb_clk_i,
  input  logic                      wb_rst_i,
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [1:0]                wb_sel_i,
  input  logic [31:0]               wb_adr_i,
  input  logic [15:0]               wb_dat_i,
  output logic [15:0]               wb_dat_o,
  output logic                      wb_ack_o,
  input  logic                      phy_ready_i,
  output logic [SOFT_ADDR_BITS-1:0] soft_addr_o,
  output logic                      ddr2_reset_o,
  output logic                      bus_rqst_o,
  input  logic                      bus_grntd_i,
  input  logic                      win_err_set_i
);

  logic [2:0]  reg_idx;
  logic        access;
  logic        wr_lane0;
  logic        win_err_q;
  logic [15:0] rd_mux;
  logic [15:0] lane_mask;
  logic [15:0] soft_ext;
  logic [15:0] soft_wr;

  assign reg_idx  = wb_adr_i[3:1];
  assign access   = wb_cyc_i & wb_stb_i & ~wb_ack_o; // Blocks a second ack.
  assign wr_lane0 = access & wb_we_i & wb_sel_i[0];

  // Byte lanes above the register width drop out in the truncation.
  assign lane_mask = {{8{wb_sel_i[1]}}, {8{wb_sel_i[0]}}};
  assign soft_ext  = 16'(soft_addr_o);
  assign soft_wr   = (soft_ext & ~lane_mask) | (wb_dat_i & lane_mask);

  always_comb begin
    case (reg_idx)
      REG_PHY_READY: rd_mux = {15'd0, phy_ready_i};
      REG_SOFT_ADDR: rd_mux = soft_ext;
      REG_BUS_RQST:  rd_mux = {15'd0, bus_rqst_o};
      REG_BUS_GRNTD: rd_mux = {15'd0, bus_grntd_i};
      REG_WIN_ERR:   rd_mux = {15'd0, win_err_q};
      default:       rd_mux = 16'h0000; // Reset register reads zero too.
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o     <= 1'b0;
      ddr2_reset_o <= 1'b0;
      soft_addr_o  <= '0;
      bus_rqst_o   <= 1'b0;
      win_err_q    <= 1'b0;
    end else begin
      wb_ack_o     <= access;
      ddr2_reset_o <= wr_lane0 && reg_idx == REG_RESET && wb_dat_i[0];
      if (access && wb_we_i && reg_idx == REG_SOFT_ADDR) begin
        soft_addr_o <= soft_wr[SOFT_ADDR_BITS-1:0];
      end
      if (wr_lane0 && reg_idx == REG_BUS_RQST) begin
        bus_rqst_o <= wb_dat_i[0];
      end
      if (win_err_set_i) begin
        win_err_q <= 1'b1; // A new error wins over a clear.
      end else if (wr_lane0 && reg_idx == REG_WIN_ERR && wb_dat_i[0]) begin
        win_err_q <= 1'b0;
      end
    end
  end

  // Read data is sampled on the strobe edge.
  always_ff @(posedge wb_clk_i) begin
    if (access) begin
      wb_dat_o <= rd_mux;
    end
  end

endmodule

//--- ddr2_mem_window/ddr2_mem_window.sv
module ddr2_mem_window
  import ddr2_cpu_pkg::*;
#(
  parameter int SOFT_ADDR_BITS = 12
) (
  input  logic                      wb_clk_i,
  input  logic                      wb_rst_i,
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [1:0]                wb_sel_i,
  input  logic [31:0]               wb_adr_i,
  input  logic [15:0]               wb_dat_i,
  output logic [15:0]               wb_dat_o,
  output logic                      wb_ack_o,
  input  logic [SOFT_ADDR_BITS-1:0] soft_addr_i,
  input  logic                      phy_ready_i,
  input  logic                      grant_i,
  output mem_cmd_t                  cmd_o,
  input  mem_rsp_t                  rsp_i,
  output logic                      err_set_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT_RD,
    ST_ACK
  } win_state_t;

  win_state_t  state_q;
  logic        start;
  logic        refuse;
  logic [31:0] mem_addr;

  assign start    = wb_cyc_i & wb_stb_i;
  assign refuse   = ~grant_i | ~phy_ready_i;
  assign mem_addr = 32'({soft_addr_i, wb_adr_i[WIN_OFS_BITS:1]}); // Page, then word offset.
  assign wb_ack_o = (state_q == ST_ACK);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q     <= ST_IDLE;
      cmd_o.valid <= 1'b0;
      err_set_o   <= 1'b0;
    end else begin
      err_set_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (start && refuse) begin
            wb_dat_o  <= 16'h0000;
            err_set_o <= 1'b1;
            state_q   <= ST_ACK;
          end else if (start) begin
            cmd_o.valid <= 1'b1;
            cmd_o.we    <= wb_we_i;
            cmd_o.sel   <= wb_sel_i;
            cmd_o.addr  <= mem_addr;
            cmd_o.wdata <= wb_dat_i;
            state_q     <= ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          if (rsp_i.ready) begin
            cmd_o.valid <= 1'b0;
            if (cmd_o.we) begin
              state_q <= ST_ACK;
            end else if (rsp_i.rvalid) begin
              wb_dat_o <= rsp_i.rdata;
              state_q  <= ST_ACK;
            end else begin
              state_q <= ST_WAIT_RD;
            end
          end
        end
        ST_WAIT_RD: begin
          if (rsp_i.rvalid) begin
            wb_dat_o <= rsp_i.rdata;
            state_q  <= ST_ACK;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // A pending command must not change before the controller takes it.
  a_cmd_hold: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    cmd_o.valid && !rsp_i.ready |=> cmd_o.valid && $stable(cmd_o)
  ) else $error("Window command changed while stalled.");

endmodule

//--- rtl/ddr2_bus_arbiter.sv
module ddr2_bus_arbiter
  import ddr2_cpu_pkg::*;
(
  input  logic     wb_clk_i,
  input  logic     wb_rst_i,
  input  logic     cpu_rqst_i,
  output logic     cpu_grnt_o,
  input  mem_cmd_t cpu_cmd_i,
  output mem_rsp_t cpu_rsp_o,
  input  logic     fab_req_i,
  output logic     fab_gnt_o,
  input  mem_cmd_t fab_cmd_i,
  output mem_rsp_t fab_rsp_o,
  output mem_cmd_t mem_cmd_o,
  input  mem_rsp_t mem_rsp_i
);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      cpu_grnt_o <= 1'b0;
      fab_gnt_o  <= 1'b0;
    end else if (cpu_grnt_o) begin
      cpu_grnt_o <= cpu_rqst_i; // Owner keeps the bus while it asks.
    end else if (fab_gnt_o) begin
      fab_gnt_o <= fab_req_i;
    end else if (cpu_rqst_i) begin
      cpu_grnt_o <= 1'b1; // CPU first on a free bus.
    end else begin
      fab_gnt_o <= fab_req_i;
    end
  end

  always_comb begin
    if (cpu_grnt_o) begin
      mem_cmd_o = cpu_cmd_i;
    end else if (fab_gnt_o) begin
      mem_cmd_o = fab_cmd_i;
    end else begin
      mem_cmd_o = '0;
    end
  end

  // Only the owner sees acceptance and read data.
  assign cpu_rsp_o = cpu_grnt_o ? mem_rsp_i : '0;
  assign fab_rsp_o = fab_gnt_o ? mem_rsp_i : '0;

  a_one_owner: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    !(cpu_grnt_o && fab_gnt_o)
  ) else $error("CPU and fabric granted at the same time.");

endmodule

//--- rtl/ddr2_cpu_if_top.sv
module ddr2_cpu_if_top
  import ddr2_cpu_pkg::*;
#(
  parameter int SOFT_ADDR_BITS = 12
) (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [1:0]  wb_sel_i,
  input  logic [31:0] wb_adr_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  output logic        wb_ack_o,
  input  logic        phy_ready_i,
  output logic        ddr2_reset_o,
  input  logic        fab_req_i,
  output logic        fab_gnt_o,
  input  mem_cmd_t    fab_cmd_i,
  output mem_rsp_t    fab_rsp_o,
  output mem_cmd_t    mem_cmd_o,
  input  mem_rsp_t    mem_rsp_i
);

  logic                      reg_stb;
  logic                      win_stb;
  logic                      reg_ack;
  logic                      win_ack;
  logic [15:0]               reg_dat;
  logic [15:0]               win_dat;
  logic [SOFT_ADDR_BITS-1:0] soft_addr;
  logic                      cpu_rqst;
  logic                      cpu_grnt;
  logic                      win_err_set;
  mem_cmd_t                  win_cmd;
  mem_rsp_t                  win_rsp;

  ddr2_wb_decode u_decode (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wb_stb_i  (wb_stb_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .reg_stb_o (reg_stb),
    .win_stb_o (win_stb),
    .reg_ack_i (reg_ack),
    .reg_dat_i (reg_dat),
    .win_ack_i (win_ack),
    .win_dat_i (win_dat)
  );

  ddr2_ctrl_regs #(
    .SOFT_ADDR_BITS(SOFT_ADDR_BITS)
  ) u_regs (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (reg_stb),
    .wb_we_i       (wb_we_i),
    .wb_sel_i      (wb_sel_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (reg_dat),
    .wb_ack_o      (reg_ack),
    .phy_ready_i   (phy_ready_i),
    .soft_addr_o   (soft_addr),
    .ddr2_reset_o  (ddr2_reset_o),
    .bus_rqst_o    (cpu_rqst),
    .bus_grntd_i   (cpu_grnt),
    .win_err_set_i (win_err_set)
  );

  ddr2_mem_window #(
    .SOFT_ADDR_BITS(SOFT_ADDR_BITS)
  ) u_window (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (win_stb),
    .wb_we_i     (wb_we_i),
    .wb_sel_i    (wb_sel_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (win_dat),
    .wb_ack_o    (win_ack),
    .soft_addr_i (soft_addr),
    .phy_ready_i (phy_ready_i),
    .grant_i     (cpu_grnt),
    .cmd_o       (win_cmd),
    .rsp_i       (win_rsp),
    .err_set_o   (win_err_set)
  );

  ddr2_bus_arbiter u_arbiter (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .cpu_rqst_i (cpu_rqst),
    .cpu_grnt_o (cpu_grnt),
    .cpu_cmd_i  (win_cmd),
    .cpu_rsp_o  (win_rsp),
    .fab_req_i  (fab_req_i),
    .fab_gnt_o  (fab_gnt_o),
    .fab_cmd_i  (fab_cmd_i),
    .fab_rsp_o  (fab_rsp_o),
    .mem_cmd_o  (mem_cmd_o),
    .mem_rsp_i  (mem_rsp_i)
  );

endmodule

//--- rtl/ddr2_wb_decode.sv
module ddr2_wb_decode
  import ddr2_cpu_pkg::*;
(
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_stb_i,
  input  logic [31:0] wb_adr_i,
  output logic [15:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        reg_stb_o,
  output logic        win_stb_o,
  input  logic        reg_ack_i,
  input  logic [15:0] reg_dat_i,
  input  logic        win_ack_i,
  input  logic [15:0] win_dat_i
);

  logic win_sel;

  assign win_sel   = wb_adr_i[WIN_SEL_BIT];
  assign reg_stb_o = wb_stb_i & ~win_sel;
  assign win_stb_o = wb_stb_i & win_sel;

  assign wb_ack_o = reg_ack_i | win_ack_i;

  always_comb begin
    if (win_ack_i) begin
      wb_dat_o = win_dat_i;
    end else if (reg_ack_i) begin
      wb_dat_o = reg_dat_i;
    end else begin
      wb_dat_o = 16'h0000;
    end
  end

  // Only one region may answer a given cycle.
  a_single_ack: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    !(reg_ack_i && win_ack_i)
  ) else $error("Register file and window acked together.");

endmodule

//--- testbench/tb_ddr2_cpu_if.sv
module tb_ddr2_cpu_if
  import ddr2_cpu_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 5000; // Far above the few hundred cycles the run needs.
  localparam int WIN_WORDS      = 8;

  logic        wb_clk;
  logic        wb_rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_sel;
  logic [31:0] wb_adr;
  logic [15:0] wb_wdata;
  logic [15:0] wb_rdata;
  logic        wb_ack;
  logic        phy_ready;
  logic        ddr2_reset;
  logic        fab_req;
  logic        fab_gnt;
  mem_cmd_t    fab_cmd;
  mem_rsp_t    fab_rsp;
  mem_cmd_t    mem_cmd;
  mem_rsp_t    mem_rsp;
  logic [31:0] last_addr;

  logic        started     = 1'b0;
  logic        cpu_owns    = 1'b0;
  logic        refuse_mode = 1'b0;
  logic [31:0] exp_addr    = '0;
  logic [11:0] soft_exp;
  int          reset_pulses = 0;
  int          cycle_count  = 0;
  logic [14:0] win_ofs [WIN_WORDS];
  logic [15:0] win_data [WIN_WORDS];

  ddr2_cpu_if_top #(
    .SOFT_ADDR_BITS(12)
  ) dut0 (
    .wb_clk_i     (wb_clk),
    .wb_rst_i     (wb_rst),
    .wb_cyc_i     (wb_cyc),
    .wb_stb_i     (wb_stb),
    .wb_we_i      (wb_we),
    .wb_sel_i     (wb_sel),
    .wb_adr_i     (wb_adr),
    .wb_dat_i     (wb_wdata),
    .wb_dat_o     (wb_rdata),
    .wb_ack_o     (wb_ack),
    .phy_ready_i  (phy_ready),
    .ddr2_reset_o (ddr2_reset),
    .fab_req_i    (fab_req),
    .fab_gnt_o    (fab_gnt),
    .fab_cmd_i    (fab_cmd),
    .fab_rsp_o    (fab_rsp),
    .mem_cmd_o    (mem_cmd),
    .mem_rsp_i    (mem_rsp)
  );

  tb_ddr2_mem_model u_mem (
    .clk_i       (wb_clk),
    .rst_i       (wb_rst),
    .cmd_i       (mem_cmd),
    .rsp_o       (mem_rsp),
    .last_addr_o (last_addr)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] reg_adr(input logic [2:0] idx);
    return {28'd0, idx, 1'b0};
  endfunction

  function automatic logic [31:0] win_adr(input logic [14:0] ofs);
    return {15'd0, 1'b1, ofs, 1'b0}; // Bit 16 selects the window.
  endfunction

  // Only the selected byte lanes take the new data, then the page keeps 12 bits.
  function automatic logic [11:0] lane_update(input logic [11:0] old, input logic [15:0] data,
                                              input logic [1:0] sel);
    logic [15:0] word;
    word = {4'd0, old};
    if (sel[0]) begin
      word[7:0] = data[7:0];
    end
    if (sel[1]) begin
      word[15:8] = data[15:8];
    end
    return word[11:0];
  endfunction

  task automatic wb_cycle(input logic we, input logic [31:0] adr, input logic [1:0] sel,
                          input logic [15:0] wdata, output logic [15:0] rdata);
    started  = 1'b1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_sel   = sel;
    wb_adr   = adr;
    wb_wdata = wdata;
    do begin
      @(posedge wb_clk);
      #1;
    end while (!wb_ack);
    rdata  = wb_rdata;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge wb_clk); // One idle cycle between accesses.
    #1;
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [1:0] sel, input logic [15:0] data);
    logic [15:0] unused;
    wb_cycle(1'b1, adr, sel, data, unused);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [15:0] data);
    wb_cycle(1'b0, adr, 2'b11, 16'h0000, data);
  endtask

  task automatic check_read(input logic [31:0] adr, input logic [15:0] exp, input string what);
    logic [15:0] got;
    wb_read(adr, got);
    assert (got == exp)
      else stop_on_error($sformatf("error wb_dat_o (%s): got %h expected %h", what, got, exp));
  endtask

  task automatic window_access(input logic we, input int i);
    logic [15:0] got;
    exp_addr = {5'd0, soft_exp, win_ofs[i]}; // Page, then word offset.
    wb_cycle(we, win_adr(win_ofs[i]), 2'b11, win_data[i], got);
    assert (last_addr == exp_addr)
      else stop_on_error($sformatf("error last_addr: got %h expected %h", last_addr, exp_addr));
    assert (we || got == win_data[i])
      else stop_on_error($sformatf("error wb_dat_o (window %0d): got %h expected %h",
                                   i, got, win_data[i]));
  endtask

  a_quiet_start: assert property (@(posedge wb_clk) disable iff (wb_rst)
    !started |-> !wb_ack && !ddr2_reset && !fab_gnt && !mem_cmd.valid)
    else stop_on_error("Output activity seen before the first access.");

  a_one_ack: assert property (@(posedge wb_clk) disable iff (wb_rst) wb_ack |=> !wb_ack)
    else stop_on_error("Acknowledge stayed high for more than one cycle.");

  a_reset_pulse: assert property (@(posedge wb_clk) disable iff (wb_rst)
    ddr2_reset |-> wb_ack ##1 !ddr2_reset)
    else stop_on_error("Controller reset was not a single pulse on ack.");

  a_cpu_owner: assert property (@(posedge wb_clk) disable iff (wb_rst)
    cpu_owns |-> !fab_gnt && fab_rsp == '0)
    else stop_on_error("Fabric was granted or answered while the CPU owned the bus.");

  a_cmd_addr: assert property (@(posedge wb_clk) disable iff (wb_rst)
    mem_cmd.valid && cpu_owns |-> mem_cmd.addr == exp_addr)
    else stop_on_error($sformatf("error mem_cmd_o.addr: got %h expected %h",
                                 $sampled(mem_cmd.addr), exp_addr));

  a_refused: assert property (@(posedge wb_clk) disable iff (wb_rst)
    refuse_mode |-> !mem_cmd.valid)
    else stop_on_error("A refused window access issued a memory command.");

  initial begin
    wb_clk = 1'b0;
    forever #5 wb_clk = ~wb_clk;
  end

  always @(posedge wb_clk) begin
    if (ddr2_reset) begin
      reset_pulses++;
    end
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      stop_on_error("Timeout: the run was still going after the cycle limit.");
    end
  end

  initial begin
    int          pulses;
    logic [15:0] data;
    void'($urandom(32'hea7f));
    wb_rst    = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_sel    = 2'b00;
    wb_adr    = '0;
    wb_wdata  = '0;
    phy_ready = 1'b1;
    fab_req   = 1'b0;
    fab_cmd   = '0;
    soft_exp  = '0;
    repeat (8) @(posedge wb_clk);
    #1;
    wb_rst = 1'b0;
    repeat (4) @(posedge wb_clk);
    #1;

    for (int i = 0; i < 7; i++) begin
      check_read(reg_adr(3'(i)), (i == REG_PHY_READY) ? 16'h0001 : 16'h0000, "after reset");
    end

    for (int s = 1; s < 4; s++) begin
      data = 16'($urandom);
      wb_write(reg_adr(REG_SOFT_ADDR), 2'(s), data);
      soft_exp = lane_update(soft_exp, data, 2'(s));
      check_read(reg_adr(REG_SOFT_ADDR), {4'd0, soft_exp}, "soft_addr");
    end

    pulses = reset_pulses;
    wb_write(reg_adr(REG_RESET), 2'b01, 16'h0001);
    assert (reset_pulses == pulses + 1)
      else stop_on_error("The controller reset did not pulse exactly once.");
    check_read(reg_adr(REG_RESET), 16'h0000, "reset register");

    fab_req = 1'b1;
    while (!fab_gnt) begin
      @(posedge wb_clk);
      #1;
    end
    wb_write(reg_adr(REG_BUS_RQST), 2'b01, 16'h0001);
    check_read(reg_adr(REG_BUS_GRNTD), 16'h0000, "bus granted while fabric owns");
    fab_req = 1'b0;
    repeat (3) @(posedge wb_clk);
    #1;
    check_read(reg_adr(REG_BUS_GRNTD), 16'h0001, "bus granted");
    cpu_owns = 1'b1;

    fab_req = 1'b1; // The fabric keeps asking while the CPU owns the bus.
    fab_cmd = '{valid: 1'b1, we: 1'b1, sel: 2'b11, addr: 32'hffff_fffe, wdata: 16'hdead};
    for (int i = 0; i < WIN_WORDS; i++) begin
      win_ofs[i]  = {7'($urandom), 8'(i * 37)};
      win_data[i] = 16'($urandom);
      window_access(1'b1, i);
    end
    for (int i = 0; i < WIN_WORDS; i++) begin
      window_access(1'b0, i);
    end
    fab_req = 1'b0;
    fab_cmd = '0;

    refuse_mode = 1'b1;
    phy_ready   = 1'b0;
    check_read(win_adr(15'h0042), 16'h0000, "window read without PHY ready");
    check_read(reg_adr(REG_PHY_READY), 16'h0000, "PHY ready");
    check_read(reg_adr(REG_WIN_ERR), 16'h0001, "window error");
    wb_write(reg_adr(REG_WIN_ERR), 2'b01, 16'h0001);
    check_read(reg_adr(REG_WIN_ERR), 16'h0000, "window error after clear");

    phy_ready = 1'b1;
    cpu_owns  = 1'b0;
    wb_write(reg_adr(REG_BUS_RQST), 2'b01, 16'h0000);
    check_read(reg_adr(REG_BUS_GRNTD), 16'h0000, "bus granted after release");
    wb_write(win_adr(15'h0042), 2'b11, 16'h1234);
    check_read(reg_adr(REG_WIN_ERR), 16'h0001, "window error without grant");
    wb_write(reg_adr(REG_WIN_ERR), 2'b01, 16'h0001);
    check_read(reg_adr(REG_WIN_ERR), 16'h0000, "window error after second clear");

    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- testbench/tb_ddr2_mem_model.sv
module tb_ddr2_mem_model
  import ddr2_cpu_pkg::*;
#(
  parameter int READ_DELAY = 3
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  mem_cmd_t    cmd_i,
  output mem_rsp_t    rsp_o,
  output logic [31:0] last_addr_o
);

  logic [15:0] mem_q [256];
  logic        stall_q;
  logic        accept;
  logic        rvalid_q;
  logic [15:0] rdata_q;
  logic [7:0]  rd_idx_q;
  int          rd_wait_q;

  assign accept = cmd_i.valid & ~stall_q;
  assign rsp_o  = {accept, rvalid_q, rdata_q};

  always @(posedge clk_i) begin
    if (rst_i) begin
      stall_q     <= 1'b0;
      rvalid_q    <= 1'b0;
      rdata_q     <= '0;
      rd_idx_q    <= '0;
      rd_wait_q   <= 0;
      last_addr_o <= '0;
    end else begin
      stall_q  <= 1'($urandom); // Refuses about half of the cycles.
      rvalid_q <= 1'b0;
      if (accept) begin
        last_addr_o <= cmd_i.addr;
        if (cmd_i.we) begin
          if (cmd_i.sel[0]) begin
            mem_q[cmd_i.addr[7:0]][7:0] <= cmd_i.wdata[7:0];
          end
          if (cmd_i.sel[1]) begin
            mem_q[cmd_i.addr[7:0]][15:8] <= cmd_i.wdata[15:8];
          end
        end else begin
          rd_idx_q  <= cmd_i.addr[7:0];
          rd_wait_q <= READ_DELAY;
        end
      end else if (rd_wait_q > 0) begin
        rd_wait_q <= rd_wait_q - 1;
        if (rd_wait_q == 1) begin
          rvalid_q <= 1'b1;
          rdata_q  <= mem_q[rd_idx_q];
        end
      end
    end
  end

endmodule
